// ==== verilog/lane_pkg.sv ====
// ------------------
// Lane package with geometry, FIFO sizing and packet layout
// ------------------
`default_nettype none

package lane_pkg;

    // Lane geometry
    localparam int NUM_ENGINES = 4;
    localparam int ENGINE_ID_W = 2;
    localparam int DATA_W      = 16;

    // FIFO sizing
    localparam int FIFO_DEPTH  = 16;
    localparam int FIFO_PTR_W  = 4;
    localparam int PROG_THRESH = 12;

    // ------------------
    // Opcodes
    // ------------------
    typedef enum logic [1:0] {
        OP_PASS = 2'd0,
        OP_ADD  = 2'd1,
        OP_READ = 2'd2
    } lane_op_e;

    localparam int OP_W = $bits(lane_op_e);

    // Lane packet is {opcode, target, data}
    localparam int LANE_PKT_W = OP_W + ENGINE_ID_W + DATA_W;

    // Request is {id, address}, response is {id, data}
    localparam int MEM_REQ_W  = ENGINE_ID_W + DATA_W;
    localparam int MEM_RESP_W = ENGINE_ID_W + DATA_W;

endpackage : lane_pkg

`default_nettype wire

// ==== verilog/lane_fifo.sv ====
// ------------------
// Synchronous FIFO with registered read data, read valid pulse
// and an almost-full level
// ------------------
`timescale 1ns/1ps
`default_nettype none

module lane_fifo
    import lane_pkg::*;
#(
    parameter int WIDTH = LANE_PKT_W
) (
    input  logic             ap_clk,
    input  logic             areset_lane_template,
    input  logic             wr_en_i,
    input  logic [WIDTH-1:0] din_i,
    input  logic             rd_en_i,
    output logic [WIDTH-1:0] dout_o,
    output logic             valid_o,
    output logic             empty_o,
    output logic             almost_full_o
);

    logic [WIDTH-1:0]      mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr_q;
    logic [FIFO_PTR_W-1:0] rd_ptr_q;
    logic [FIFO_PTR_W:0]   count_q;
    logic                  push;
    logic                  pop;

    assign push = wr_en_i;
    // Pops on an empty FIFO are ignored
    assign pop  = rd_en_i & ~empty_o;

    assign empty_o       = (count_q == '0);
    assign almost_full_o = (count_q >= PROG_THRESH);

    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            valid_o  <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + {{FIFO_PTR_W{1'b0}}, push} - {{FIFO_PTR_W{1'b0}}, pop};
            valid_o <= pop;
        end
    end

    // Storage and read register
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr_q] <= din_i;
        end
        if (pop) begin
            dout_o <= mem[rd_ptr_q];
        end
    end

endmodule : lane_fifo

`default_nettype wire

// ==== verilog/lane_engine.sv ====
// ------------------
// Lane engine that passes packets, adds its index to targeted
// adds, and turns targeted reads into memory requests
// ------------------
`timescale 1ns/1ps
`default_nettype none

module lane_engine
    import lane_pkg::*;
#(
    parameter int ENGINE_INDEX = 0
) (
    input  logic                  ap_clk,
    input  logic                  areset_lane_template,
    input  logic                  in_valid_i,
    input  logic [LANE_PKT_W-1:0] in_pkt_i,
    output logic                  in_ready_o,
    output logic                  out_valid_o,
    output logic [LANE_PKT_W-1:0] out_pkt_o,
    input  logic                  out_ready_i,
    output logic                  mem_req_o,
    output logic [DATA_W-1:0]     mem_addr_o,
    input  logic                  mem_grant_i,
    input  logic                  resp_valid_i,
    input  logic [DATA_W-1:0]     resp_data_i,
    output logic                  resp_busy_o
);

    localparam logic [ENGINE_ID_W-1:0] MY_ID  = ENGINE_ID_W'(ENGINE_INDEX);
    localparam logic [DATA_W-1:0]      ADD_INC = DATA_W'(ENGINE_INDEX + 1);

    lane_op_e               in_op;
    logic [ENGINE_ID_W-1:0] in_target;
    logic [DATA_W-1:0]      in_data;
    logic                   hit;
    logic                   is_read;
    logic                   out_free;
    logic                   take_in;
    logic                   drain_slot;

    logic                   slot_valid_q;
    logic [DATA_W-1:0]      slot_data_q;
    logic                   req_pending_q;

    // ------------------
    // Packet decode
    // ------------------
    assign in_op     = lane_op_e'(in_pkt_i[LANE_PKT_W-1 -: OP_W]);
    assign in_target = in_pkt_i[DATA_W +: ENGINE_ID_W];
    assign in_data   = in_pkt_i[DATA_W-1:0];
    assign hit       = (in_target == MY_ID);
    assign is_read   = hit & (in_op == OP_READ);

    // Output register is free when empty or leaving this cycle
    assign out_free = ~out_valid_o | out_ready_i;

    // Responses go first, and no input while a read is outstanding
    assign in_ready_o = out_free & ~slot_valid_q & ~resp_valid_i & ~req_pending_q;
    assign take_in    = in_valid_i & in_ready_o;
    assign drain_slot = slot_valid_q & out_free;

    assign resp_busy_o = slot_valid_q | resp_valid_i;
    assign mem_req_o   = req_pending_q;

    // ------------------
    // Control state
    // ------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            out_valid_o   <= 1'b0;
            slot_valid_q  <= 1'b0;
            req_pending_q <= 1'b0;
        end else begin
            if (drain_slot || (take_in && !is_read)) begin
                out_valid_o <= 1'b1;
            end else if (out_ready_i) begin
                out_valid_o <= 1'b0;
            end

            if (resp_valid_i) begin
                slot_valid_q <= 1'b1;
            end else if (drain_slot) begin
                slot_valid_q <= 1'b0;
            end

            // Held until the arbiter picks this engine
            if (take_in && is_read) begin
                req_pending_q <= 1'b1;
            end else if (mem_grant_i) begin
                req_pending_q <= 1'b0;
            end
        end
    end

    // ------------------
    // Payload registers
    // ------------------
    always_ff @(posedge ap_clk) begin
        if (drain_slot) begin
            out_pkt_o <= {OP_PASS, MY_ID, slot_data_q};
        end else if (take_in) begin
            if (hit && in_op == OP_ADD) begin
                out_pkt_o <= {in_op, in_target, in_data + ADD_INC};
            end else begin
                out_pkt_o <= in_pkt_i;
            end
        end

        if (resp_valid_i) begin
            slot_data_q <= resp_data_i;
        end

        // Read address is the packet data
        if (take_in && is_read) begin
            mem_addr_o <= in_data;
        end
    end

endmodule : lane_engine

`default_nettype wire

// ==== verilog/mem_request_arbiter.sv ====
// ------------------
// Round-robin arbiter that feeds engine memory requests into
// the shared request FIFO
// ------------------
`timescale 1ns/1ps
`default_nettype none

module mem_request_arbiter
    import lane_pkg::*;
(
    input  logic                   ap_clk,
    input  logic                   areset_lane_template,
    input  logic [NUM_ENGINES-1:0] req_i,
    input  logic [DATA_W-1:0]      addr_i [NUM_ENGINES],
    input  logic                   fifo_almost_full_i,
    output logic [NUM_ENGINES-1:0] grant_o,
    output logic                   push_o,
    output logic [MEM_REQ_W-1:0]   push_req_o
);

    logic [ENGINE_ID_W-1:0] ptr_q;
    logic [ENGINE_ID_W-1:0] idx;
    logic [ENGINE_ID_W-1:0] win_id;
    logic                   found;
    logic                   granted;

    // Search from the priority pointer, wrapping around
    always_comb begin
        win_id = ptr_q;
        found  = 1'b0;
        idx    = ptr_q;
        for (int k = 0; k < NUM_ENGINES; k++) begin
            idx = ENGINE_ID_W'((int'(ptr_q) + k) % NUM_ENGINES);
            if (!found && req_i[idx]) begin
                found  = 1'b1;
                win_id = idx;
            end
        end
    end

    // No grant while the request FIFO is nearly full
    assign granted = found & ~fifo_almost_full_i;

    always_comb begin
        grant_o = '0;
        if (granted) begin
            grant_o[win_id] = 1'b1;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            ptr_q  <= '0;
            push_o <= 1'b0;
        end else begin
            push_o <= granted;
            // Move priority just past the winner
            if (granted) begin
                if (win_id == ENGINE_ID_W'(NUM_ENGINES - 1)) begin
                    ptr_q <= '0;
                end else begin
                    ptr_q <= win_id + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (granted) begin
            push_req_o <= {win_id, addr_i[win_id]};
        end
    end

endmodule : mem_request_arbiter

`default_nettype wire

// ==== verilog/mem_response_router.sv ====
// ------------------
// Routes each memory response to the engine named by its id
// ------------------
`timescale 1ns/1ps
`default_nettype none

module mem_response_router
    import lane_pkg::*;
(
    input  logic                   ap_clk,
    input  logic                   areset_lane_template,
    input  logic                   fifo_valid_i,
    input  logic [MEM_RESP_W-1:0]  fifo_resp_i,
    input  logic                   fifo_empty_i,
    output logic                   fifo_rd_en_o,
    input  logic [NUM_ENGINES-1:0] busy_i,
    output logic [NUM_ENGINES-1:0] resp_valid_o,
    output logic [DATA_W-1:0]      resp_data_o
);

    logic                   held_q;
    logic [ENGINE_ID_W-1:0] head_id;
    logic                   release_head;

    // FIFO read data stays put until the next pop
    assign head_id      = fifo_resp_i[MEM_RESP_W-1 -: ENGINE_ID_W];
    assign release_head = held_q & ~busy_i[head_id];

    // One pop in flight at most
    assign fifo_rd_en_o = ~fifo_empty_i & ~fifo_valid_i & (~held_q | release_head);

    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            held_q       <= 1'b0;
            resp_valid_o <= '0;
        end else begin
            if (fifo_valid_i) begin
                held_q <= 1'b1;
            end else if (release_head) begin
                held_q <= 1'b0;
            end
            resp_valid_o <= '0;
            if (release_head) begin
                resp_valid_o[head_id] <= 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (release_head) begin
            resp_data_o <= fifo_resp_i[DATA_W-1:0];
        end
    end

endmodule : mem_response_router

`default_nettype wire

// ==== verilog/lane_top.sv ====
// ------------------
// Lane top with input and output FIFOs, the engine chain and
// the shared memory request and response path
// ------------------
`timescale 1ns/1ps
`default_nettype none

module lane_top
    import lane_pkg::*;
(
    input  logic                   ap_clk,
    input  logic                   areset_lane_template,
    input  logic                   lane_in_valid_i,
    input  lane_op_e               lane_in_op_i,
    input  logic [ENGINE_ID_W-1:0] lane_in_target_i,
    input  logic [DATA_W-1:0]      lane_in_data_i,
    output logic                   lane_in_full_o,
    input  logic                   lane_out_rd_en_i,
    output logic                   lane_out_valid_o,
    output lane_op_e               lane_out_op_o,
    output logic [ENGINE_ID_W-1:0] lane_out_target_o,
    output logic [DATA_W-1:0]      lane_out_data_o,
    input  logic                   mem_req_rd_en_i,
    output logic                   mem_req_valid_o,
    output logic [ENGINE_ID_W-1:0] mem_req_id_o,
    output logic [DATA_W-1:0]      mem_req_addr_o,
    input  logic                   mem_resp_valid_i,
    input  logic [ENGINE_ID_W-1:0] mem_resp_id_i,
    input  logic [DATA_W-1:0]      mem_resp_data_i,
    output logic                   mem_resp_full_o
);

    logic                   lane_in_valid_q;
    logic [LANE_PKT_W-1:0]  lane_in_pkt_q;
    logic                   mem_resp_valid_q;
    logic [MEM_RESP_W-1:0]  mem_resp_q;

    // Index i of the chain feeds engine i
    logic [NUM_ENGINES:0]   chain_valid;
    logic [NUM_ENGINES:0]   chain_ready;
    logic [LANE_PKT_W-1:0]  chain_pkt [NUM_ENGINES+1];

    logic                   in_af;
    logic                   in_empty;
    logic                   in_rd_en;
    logic                   out_af;
    logic                   out_valid;
    logic [LANE_PKT_W-1:0]  out_dout;
    logic                   req_af;
    logic                   req_valid;
    logic [MEM_REQ_W-1:0]   req_dout;
    logic                   resp_af;
    logic                   resp_valid;
    logic                   resp_empty;
    logic [MEM_RESP_W-1:0]  resp_dout;
    logic                   router_rd_en;

    logic [NUM_ENGINES-1:0] eng_req;
    logic [DATA_W-1:0]      eng_addr [NUM_ENGINES];
    logic [NUM_ENGINES-1:0] eng_grant;
    logic [NUM_ENGINES-1:0] eng_resp_busy;
    logic [NUM_ENGINES-1:0] eng_resp_valid;
    logic [NUM_ENGINES-1:0] router_busy;
    logic                   arb_push;
    logic [MEM_REQ_W-1:0]   arb_push_req;
    logic [DATA_W-1:0]      routed_data;

    // ------------------
    // Edge registers
    // ------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            lane_in_valid_q  <= 1'b0;
            mem_resp_valid_q <= 1'b0;
            lane_in_full_o   <= 1'b0;
            mem_resp_full_o  <= 1'b0;
            lane_out_valid_o <= 1'b0;
            mem_req_valid_o  <= 1'b0;
        end else begin
            lane_in_valid_q  <= lane_in_valid_i;
            mem_resp_valid_q <= mem_resp_valid_i;
            lane_in_full_o   <= in_af;
            mem_resp_full_o  <= resp_af;
            lane_out_valid_o <= out_valid;
            mem_req_valid_o  <= req_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        lane_in_pkt_q     <= {lane_in_op_i, lane_in_target_i, lane_in_data_i};
        mem_resp_q        <= {mem_resp_id_i, mem_resp_data_i};
        lane_out_op_o     <= lane_op_e'(out_dout[LANE_PKT_W-1 -: OP_W]);
        lane_out_target_o <= out_dout[DATA_W +: ENGINE_ID_W];
        lane_out_data_o   <= out_dout[DATA_W-1:0];
        mem_req_id_o      <= req_dout[MEM_REQ_W-1 -: ENGINE_ID_W];
        mem_req_addr_o    <= req_dout[DATA_W-1:0];
    end

    // ------------------
    // Lane FIFOs
    // ------------------
    // Engine 0 sees popped data a cycle late, so one pop at a time
    assign in_rd_en = chain_ready[0] & ~chain_valid[0] & ~in_empty;

    lane_fifo #(.WIDTH(LANE_PKT_W)) u_lane_in_fifo (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .wr_en_i             (lane_in_valid_q),
        .din_i               (lane_in_pkt_q),
        .rd_en_i             (in_rd_en),
        .dout_o              (chain_pkt[0]),
        .valid_o             (chain_valid[0]),
        .empty_o             (in_empty),
        .almost_full_o       (in_af)
    );

    assign chain_ready[NUM_ENGINES] = ~out_af;

    lane_fifo #(.WIDTH(LANE_PKT_W)) u_lane_out_fifo (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .wr_en_i             (chain_valid[NUM_ENGINES] & ~out_af),
        .din_i               (chain_pkt[NUM_ENGINES]),
        .rd_en_i             (lane_out_rd_en_i),
        .dout_o              (out_dout),
        .valid_o             (out_valid),
        .empty_o             (),
        .almost_full_o       (out_af)
    );

    // ------------------
    // Engine chain
    // ------------------
    for (genvar i = 0; i < NUM_ENGINES; i++) begin : g_engine
        lane_engine #(.ENGINE_INDEX(i)) u_engine (
            .ap_clk              (ap_clk),
            .areset_lane_template(areset_lane_template),
            .in_valid_i          (chain_valid[i]),
            .in_pkt_i            (chain_pkt[i]),
            .in_ready_o          (chain_ready[i]),
            .out_valid_o         (chain_valid[i+1]),
            .out_pkt_o           (chain_pkt[i+1]),
            .out_ready_i         (chain_ready[i+1]),
            .mem_req_o           (eng_req[i]),
            .mem_addr_o          (eng_addr[i]),
            .mem_grant_i         (eng_grant[i]),
            .resp_valid_i        (eng_resp_valid[i]),
            .resp_data_i         (routed_data),
            .resp_busy_o         (eng_resp_busy[i])
        );
    end

    // ------------------
    // Memory side-path
    // ------------------
    mem_request_arbiter u_arbiter (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .req_i               (eng_req),
        .addr_i              (eng_addr),
        .fifo_almost_full_i  (req_af),
        .grant_o             (eng_grant),
        .push_o              (arb_push),
        .push_req_o          (arb_push_req)
    );

    lane_fifo #(.WIDTH(MEM_REQ_W)) u_mem_req_fifo (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .wr_en_i             (arb_push),
        .din_i               (arb_push_req),
        .rd_en_i             (mem_req_rd_en_i),
        .dout_o              (req_dout),
        .valid_o             (req_valid),
        .empty_o             (),
        .almost_full_o       (req_af)
    );

    lane_fifo #(.WIDTH(MEM_RESP_W)) u_mem_resp_fifo (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .wr_en_i             (mem_resp_valid_q),
        .din_i               (mem_resp_q),
        .rd_en_i             (router_rd_en),
        .dout_o              (resp_dout),
        .valid_o             (resp_valid),
        .empty_o             (resp_empty),
        .almost_full_o       (resp_af)
    );

    // Hold off engine 0 responses while a lane pop is in flight
    assign router_busy = eng_resp_busy | {{(NUM_ENGINES-1){1'b0}}, in_rd_en};

    mem_response_router u_router (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .fifo_valid_i        (resp_valid),
        .fifo_resp_i         (resp_dout),
        .fifo_empty_i        (resp_empty),
        .fifo_rd_en_o        (router_rd_en),
        .busy_i              (router_busy),
        .resp_valid_o        (eng_resp_valid),
        .resp_data_o         (routed_data)
    );

endmodule : lane_top

`default_nettype wire

// ==== dv/lane_tb.sv ====
// ------------------
// Testbench for the lane with a memory model and an
// any-order scoreboard
// ------------------
`timescale 1ns/1ps
`default_nettype none

module lane_tb
    import lane_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 2;
    localparam int IDLE_CYCLES  = 4;
    localparam int DRAIN_CYCLES = 60;
    localparam int RAND_SEED    = 32'h6aa8_0965;
    localparam logic [DATA_W-1:0] MEM_XOR = 16'hA5C3;

    logic                   ap_clk;
    logic                   areset_lane_template;
    logic                   lane_in_valid_i;
    lane_op_e               lane_in_op_i;
    logic [ENGINE_ID_W-1:0] lane_in_target_i;
    logic [DATA_W-1:0]      lane_in_data_i;
    logic                   lane_in_full_o;
    logic                   lane_out_rd_en_i;
    logic                   lane_out_valid_o;
    lane_op_e               lane_out_op_o;
    logic [ENGINE_ID_W-1:0] lane_out_target_o;
    logic [DATA_W-1:0]      lane_out_data_o;
    logic                   mem_req_rd_en_i;
    logic                   mem_req_valid_o;
    logic [ENGINE_ID_W-1:0] mem_req_id_o;
    logic [DATA_W-1:0]      mem_req_addr_o;
    logic                   mem_resp_valid_i;
    logic [ENGINE_ID_W-1:0] mem_resp_id_i;
    logic [DATA_W-1:0]      mem_resp_data_i;
    logic                   mem_resp_full_o;

    // Stimulus vectors in file order
    lane_op_e               vec_op [$];
    logic [ENGINE_ID_W-1:0] vec_tgt [$];
    logic [DATA_W-1:0]      vec_data [$];

    // Pending expectations and the vector behind each one
    logic [LANE_PKT_W-1:0]  exp_pkt [$];
    string                  exp_pkt_name [$];
    logic [MEM_REQ_W-1:0]   exp_req [$];
    string                  exp_req_name [$];

    // Memory model queue, each entry with its due cycle
    logic [MEM_REQ_W-1:0]   mem_pend [$];
    int                     mem_pend_due [$];

    int num_vec;
    int num_reads;
    int next_vec;
    int cycle_cnt;
    int cycle_limit;
    int out_count;
    int req_count;
    int value_errs;
    int other_errs;

    lane_top dut (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .lane_in_valid_i     (lane_in_valid_i),
        .lane_in_op_i        (lane_in_op_i),
        .lane_in_target_i    (lane_in_target_i),
        .lane_in_data_i      (lane_in_data_i),
        .lane_in_full_o      (lane_in_full_o),
        .lane_out_rd_en_i    (lane_out_rd_en_i),
        .lane_out_valid_o    (lane_out_valid_o),
        .lane_out_op_o       (lane_out_op_o),
        .lane_out_target_o   (lane_out_target_o),
        .lane_out_data_o     (lane_out_data_o),
        .mem_req_rd_en_i     (mem_req_rd_en_i),
        .mem_req_valid_o     (mem_req_valid_o),
        .mem_req_id_o        (mem_req_id_o),
        .mem_req_addr_o      (mem_req_addr_o),
        .mem_resp_valid_i    (mem_resp_valid_i),
        .mem_resp_id_i       (mem_resp_id_i),
        .mem_resp_data_i     (mem_resp_data_i),
        .mem_resp_full_o     (mem_resp_full_o)
    );

    initial begin
        ap_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
    end

    // ------------------
    // Vector file
    // ------------------
    task automatic load_vectors();
        int       fd;
        int       code;
        int       ch;
        int       f_op;
        int       f_tgt;
        int       f_data;
        int       f_etgt;
        int       f_edata;
        lane_op_e op;
        lane_op_e exp_op;
        string    name;
        fd = $fopen("dv/lane_input.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("Cannot open the stimulus file dv/lane_input.txt");
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%h %h %h %h %h\n", f_op, f_tgt, f_data, f_etgt, f_edata);
            if (code == 5) begin
                op   = lane_op_e'(f_op[OP_W-1:0]);
                name = $sformatf("vec%0d_%s", num_vec, op.name());
                vec_op.push_back(op);
                vec_tgt.push_back(f_tgt[ENGINE_ID_W-1:0]);
                vec_data.push_back(f_data[DATA_W-1:0]);
                // A read returns from its engine as a pass
                exp_op = (op == OP_READ) ? OP_PASS : op;
                exp_pkt.push_back({exp_op, f_etgt[ENGINE_ID_W-1:0], f_edata[DATA_W-1:0]});
                exp_pkt_name.push_back(name);
                if (op == OP_READ) begin
                    exp_req.push_back({f_tgt[ENGINE_ID_W-1:0], f_data[DATA_W-1:0]});
                    exp_req_name.push_back(name);
                    num_reads++;
                end
                num_vec++;
            end else begin
                // Skip the rest of a comment line
                ch = $fgetc(fd);
                while (ch != -1 && ch != 10) begin
                    ch = $fgetc(fd);
                end
            end
        end
        $fclose(fd);
    endtask

    // ------------------
    // Scoreboard
    // ------------------
    task automatic check_output();
        logic [LANE_PKT_W-1:0] pkt;
        int                    hit;
        int                    near;
        pkt  = {lane_out_op_o, lane_out_target_o, lane_out_data_o};
        hit  = -1;
        near = -1;
        foreach (exp_pkt[k]) begin
            if (hit < 0 && exp_pkt[k] == pkt) begin
                hit = k;
            end
            // Same opcode and target, so likely the same vector
            if (near < 0 && exp_pkt[k][LANE_PKT_W-1:DATA_W] == pkt[LANE_PKT_W-1:DATA_W]) begin
                near = k;
            end
        end
        out_count++;
        assert (hit >= 0) else begin
            if (near >= 0) begin
                value_errs++;
                $display("Fail %s: expected %h actual %h", exp_pkt_name[near], exp_pkt[near],
                         pkt);
                hit = near;
            end else begin
                other_errs++;
                $display("Lane output op %0d target %0d data %h matches no pending vector",
                         lane_out_op_o, lane_out_target_o, lane_out_data_o);
            end
        end
        if (hit >= 0) begin
            exp_pkt.delete(hit);
            exp_pkt_name.delete(hit);
        end
    endtask

    task automatic check_request();
        logic [MEM_REQ_W-1:0] req;
        int                   hit;
        int                   near;
        req  = {mem_req_id_o, mem_req_addr_o};
        hit  = -1;
        near = -1;
        foreach (exp_req[k]) begin
            if (hit < 0 && exp_req[k] == req) begin
                hit = k;
            end
            if (near < 0 && exp_req[k][MEM_REQ_W-1:DATA_W] == mem_req_id_o) begin
                near = k;
            end
        end
        req_count++;
        assert (hit >= 0) else begin
            if (near >= 0) begin
                value_errs++;
                $display("Fail %s: expected %h actual %h", exp_req_name[near], exp_req[near],
                         req);
                hit = near;
            end else begin
                other_errs++;
                $display("Memory request id %0d addr %h matches no pending read",
                         mem_req_id_o, mem_req_addr_o);
            end
        end
        if (hit >= 0) begin
            exp_req.delete(hit);
            exp_req_name.delete(hit);
        end
        mem_pend.push_back(req);
        mem_pend_due.push_back(cycle_cnt + int'($urandom_range(5, 0)));
    endtask

    // ------------------
    // Memory model and stimulus
    // ------------------
    task automatic serve_memory();
        logic [MEM_REQ_W-1:0] req;
        mem_resp_valid_i = 1'b0;
        if (mem_pend.size() > 0 && mem_pend_due[0] <= cycle_cnt && !mem_resp_full_o) begin
            req = mem_pend.pop_front();
            mem_pend_due.delete(0);
            mem_resp_valid_i = 1'b1;
            mem_resp_id_i    = req[MEM_REQ_W-1:DATA_W];
            mem_resp_data_i  = req[DATA_W-1:0] ^ MEM_XOR;
        end
    endtask

    task automatic drive_lane_input();
        lane_in_valid_i = 1'b0;
        if (cycle_cnt > IDLE_CYCLES && next_vec < num_vec && !lane_in_full_o) begin
            lane_in_valid_i  = 1'b1;
            lane_in_op_i     = vec_op[next_vec];
            lane_in_target_i = vec_tgt[next_vec];
            lane_in_data_i   = vec_data[next_vec];
            next_vec++;
        end
    endtask

    // One falling edge of work
    task automatic run_cycle();
        if (cycle_cnt <= IDLE_CYCLES) begin
            assert (!lane_out_valid_o && !mem_req_valid_o && !lane_in_full_o &&
                    !mem_resp_full_o) else begin
                value_errs++;
                $display("Fail reset_idle: expected 0000 actual %b%b%b%b", lane_out_valid_o,
                         mem_req_valid_o, lane_in_full_o, mem_resp_full_o);
            end
        end
        if (lane_out_valid_o) begin
            check_output();
        end
        if (mem_req_valid_o) begin
            check_request();
        end
        serve_memory();
        // Random stalls on both read sides
        lane_out_rd_en_i = ($urandom_range(3, 0) != 0);
        mem_req_rd_en_i  = ($urandom_range(2, 0) != 0);
        drive_lane_input();
    endtask

    initial begin
        int seed_init;
        seed_init = $urandom(RAND_SEED);
        areset_lane_template = 1'b1;
        lane_in_valid_i  = 1'b0;
        lane_in_op_i     = OP_PASS;
        lane_in_target_i = '0;
        lane_in_data_i   = '0;
        lane_out_rd_en_i = 1'b0;
        mem_req_rd_en_i  = 1'b0;
        mem_resp_valid_i = 1'b0;
        mem_resp_id_i    = '0;
        mem_resp_data_i  = '0;
        num_vec    = 0;
        num_reads  = 0;
        next_vec   = 0;
        cycle_cnt  = 0;
        out_count  = 0;
        req_count  = 0;
        value_errs = 0;
        other_errs = 0;
        load_vectors();
        cycle_limit = 200 * num_vec + 1000;

        repeat (RESET_CYCLES) begin
            @(negedge ap_clk);
        end
        areset_lane_template = 1'b0;

        while (out_count < num_vec && cycle_cnt < cycle_limit) begin
            @(negedge ap_clk);
            cycle_cnt++;
            run_cycle();
        end
        if (out_count < num_vec) begin
            other_errs++;
            $display("Timeout after %0d cycles with %0d of %0d lane outputs seen",
                     cycle_cnt, out_count, num_vec);
        end else begin
            // Idle tail so that late duplicates show up
            repeat (DRAIN_CYCLES) begin
                @(negedge ap_clk);
                cycle_cnt++;
                run_cycle();
            end
        end

        assert (num_vec > 0) else begin
            other_errs++;
            $display("No stimulus vectors were loaded");
        end
        assert (out_count == num_vec) else begin
            value_errs++;
            $display("Fail output_count: expected %0d actual %0d", num_vec, out_count);
        end
        assert (req_count == num_reads) else begin
            value_errs++;
            $display("Fail request_count: expected %0d actual %0d", num_reads, req_count);
        end
        assert (exp_pkt.size() == 0) else begin
            other_errs++;
            $display("%0d expected lane outputs never appeared, first one is %s",
                     exp_pkt.size(), exp_pkt_name[0]);
        end

        $display("Errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : lane_tb

`default_nettype wire

// ==== dv/lane_input.txt ====
// Columns are opcode, target, data, expected target and expected data in hex
// Opcode 0 is pass, 1 is add and 2 is read
0 0 1234 0 1234
0 3 beef 3 beef
0 2 5a5a 2 5a5a
1 0 0010 0 0011
1 1 0010 1 0012
1 2 0010 2 0013
1 3 0010 3 0014
1 3 ffff 3 0003
1 2 7ffe 2 8001
2 0 1000 0 b5c3
2 1 2000 1 85c3
2 2 3000 2 95c3
2 3 4000 3 e5c3
2 1 00ff 1 a53c
2 3 a5c3 3 0000
2 0 ffff 0 5a3c
1 0 0000 0 0001
0 1 0000 1 0000

// ==== lane.f ====
verilog/lane_pkg.sv
verilog/lane_fifo.sv
verilog/lane_engine.sv
verilog/mem_request_arbiter.sv
verilog/mem_response_router.sv
verilog/lane_top.sv
dv/lane_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --assert
TOP       ?= lane_tb
FILELIST  ?= lane.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf $(OBJ_DIR)
